// File: src/mdioPkg.sv
/*
  MDIO register map package: PHY shadow addresses, user register addresses,
  control field layout and the request/receive structs toward the MDIO engine
*/
`default_nettype none

package mdioPkg;

  //========================================
  // word addressing
  //========================================
  // AXI byte address bits 7:2 pick a 32-bit word
  localparam int RegAddrLsb   = 2;
  localparam int RegAddrMsb   = 7;
  localparam int RegAddrWidth = 6;
  typedef logic [RegAddrWidth-1:0] regAddr_t;

  //========================================
  // PHY register map (LAN8720-class)
  //========================================
  // basic registers
  localparam regAddr_t PhyCtrlAddr     = 6'h00;
  localparam regAddr_t PhyStatAddr     = 6'h01;
  // extended registers
  localparam regAddr_t PhyIdent1Addr   = 6'h02;
  localparam regAddr_t PhyIdent2Addr   = 6'h03;
  localparam regAddr_t PhyAnaAddr      = 6'h04;
  localparam regAddr_t PhyAnlpAddr     = 6'h05;
  localparam regAddr_t PhyAneAddr      = 6'h06;
  // vendor-specific registers
  localparam regAddr_t PhyModeAddr     = 6'h11;
  localparam regAddr_t PhySpecModeAddr = 6'h12;
  localparam regAddr_t PhySymErrAddr   = 6'h1A;
  localparam regAddr_t PhyIndcAddr     = 6'h1B;
  localparam regAddr_t PhyIntrSrcAddr  = 6'h1D;
  localparam regAddr_t PhyIntrMskAddr  = 6'h1E;
  localparam regAddr_t PhySpecCtrlAddr = 6'h1F;

  // shadow slot i holds the PHY register at PhyMap[i]
  localparam int PhyRegCount = 14;
  localparam regAddr_t PhyMap [PhyRegCount] = '{
    PhyCtrlAddr, PhyStatAddr, PhyIdent1Addr, PhyIdent2Addr, PhyAnaAddr,
    PhyAnlpAddr, PhyAneAddr, PhyModeAddr, PhySpecModeAddr, PhySymErrAddr,
    PhyIndcAddr, PhyIntrSrcAddr, PhyIntrMskAddr, PhySpecCtrlAddr
  };

  // processor-written registers
  localparam regAddr_t UsrCtrlAddr  = 6'h20;
  localparam regAddr_t UsrWriteAddr = 6'h21;

  //========================================
  // control register fields
  //========================================
  // bit 0 enable, bit 1 write (0 = read), 6:2 PHY addr, 11:7 reg addr
  localparam int CtrlEnBit     = 0;
  localparam int CtrlWriteBit  = 1;
  localparam int CtrlPhyLsb    = 2;
  localparam int CtrlRegLsb    = 7;
  localparam int PhyFieldWidth = 5;

  typedef logic [15:0] phyData_t;

  // request levels toward the MDIO engine
  typedef struct packed {
    logic [PhyFieldWidth-1:0] phyAddr;
    logic [PhyFieldWidth-1:0] regAddr;
    logic                     write;
    logic                     en;
    phyData_t                 wrData;
  } mdioReq_t;

  // register contents returned by the MDIO engine
  typedef struct packed {
    regAddr_t regAddr;
    logic     valid;
    phyData_t data;
  } mdioRecv_t;

endpackage

`default_nettype wire

// File: src/axiLitePkg.sv
/*
  AXI4-Lite package: bus widths, response codes, channel structs
  and the internal register write command
*/
`default_nettype none

package axiLitePkg;

  localparam int AxiAddrWidth = 32;
  localparam int AxiDataWidth = 32;

  typedef logic [AxiAddrWidth-1:0] axiAddr_t;
  typedef logic [AxiDataWidth-1:0] axiData_t;

  // only OKAY is ever returned
  typedef logic [1:0] axiResp_t;
  localparam axiResp_t RespOkay = 2'b00;

  //========================================
  // channels, master to slave
  //========================================
  typedef struct packed {
    axiAddr_t addr;
    logic     valid;
  } awChan_t;

  typedef struct packed {
    axiData_t data;
    logic     valid;
  } wChan_t;

  typedef struct packed {
    axiAddr_t addr;
    logic     valid;
  } arChan_t;

  //========================================
  // channels, slave to master
  //========================================
  typedef struct packed {
    logic     valid;
    axiResp_t resp;
  } bChan_t;

  typedef struct packed {
    logic     valid;
    axiData_t data;
    axiResp_t resp;
  } rChan_t;

  // one-cycle write command to the register file
  typedef struct packed {
    logic              strobe;
    mdioPkg::regAddr_t addr;
    axiData_t          data;
  } regWrite_t;

endpackage

`default_nettype wire

// File: src/axiLiteSlave.sv
/*
  AXI4-Lite slave: single-beat read/write FSM, busy level synchronizer
  and read data capture at the moment the read is accepted
*/
`timescale 1ns/1ns
`default_nettype none

module axiLiteSlave (
  input  wire                 axiClk,
  input  wire                 arstN,
  // AXI master side
  input  axiLitePkg::awChan_t awChan,
  input  axiLitePkg::wChan_t  wChan,
  input  axiLitePkg::arChan_t arChan,
  input  wire                 bready,
  input  wire                 rready,
  output logic                awready,
  output logic                wready,
  output logic                arready,
  output axiLitePkg::bChan_t  bChan,
  output axiLitePkg::rChan_t  rChan,
  // MDIO engine busy, mdcClk domain
  input  wire                 mdioBusy,
  // register file side
  output axiLitePkg::regWrite_t regWrite,
  output mdioPkg::regAddr_t   readAddr,
  input  axiLitePkg::axiData_t userRdata,
  input  axiLitePkg::axiData_t phyRdata
);

  import axiLitePkg::*;
  import mdioPkg::*;

  typedef enum logic [1:0] {
    StIdle,
    StRead,
    StWrite,
    StAck
  } state_t;

  state_t   state;
  logic     busyMeta;
  logic     busySync;
  logic     writeStrobe;
  logic     bValid;
  logic     rValid;
  axiData_t rData;

  //========================================
  // busy crossing
  //========================================
  // two flops, FSM sees the level two edges later
  always_ff @(posedge axiClk or negedge arstN) begin
    if (!arstN) begin
      busyMeta <= 1'b0;
      busySync <= 1'b0;
    end else begin
      busyMeta <= mdioBusy;
      busySync <= busyMeta;
    end
  end

  //========================================
  // transaction FSM
  //========================================
  always_ff @(posedge axiClk or negedge arstN) begin
    if (!arstN) begin
      state       <= StIdle;
      awready     <= 1'b0;
      wready      <= 1'b0;
      arready     <= 1'b0;
      writeStrobe <= 1'b0;
      bValid      <= 1'b0;
      rValid      <= 1'b0;
      rData       <= '0;
      readAddr    <= '0;
    end else begin
      case (state)
        StIdle: begin
          // writes take priority, nothing starts while the engine is busy
          if (awChan.valid && wChan.valid && !busySync) begin
            awready     <= 1'b1;
            wready      <= 1'b1;
            writeStrobe <= 1'b1;
            state       <= StWrite;
          end else if (arChan.valid && !busySync) begin
            readAddr <= arChan.addr[RegAddrMsb:RegAddrLsb];
            arready  <= 1'b1;
            state    <= StRead;
          end
        end
        StRead: begin
          // readAddr is settled here, so capture the word now
          arready <= 1'b0;
          rData   <= userRdata | phyRdata;
          rValid  <= 1'b1;
          state   <= StAck;
        end
        StWrite: begin
          awready     <= 1'b0;
          wready      <= 1'b0;
          writeStrobe <= 1'b0;
          bValid      <= 1'b1;
          state       <= StAck;
        end
        StAck: begin
          // hold the pending response until the master takes it
          if (bValid && bready) begin
            bValid <= 1'b0;
            state  <= StIdle;
          end
          if (rValid && rready) begin
            rValid <= 1'b0;
            state  <= StIdle;
          end
        end
        default: begin
          state <= StIdle;
        end
      endcase
    end
  end

  //========================================
  // outputs
  //========================================
  // address and data stay valid on the bus through the handshake cycle
  assign regWrite.strobe = writeStrobe;
  assign regWrite.addr   = awChan.addr[RegAddrMsb:RegAddrLsb];
  assign regWrite.data   = wChan.data;

  assign bChan.valid = bValid;
  assign bChan.resp  = RespOkay;

  assign rChan.valid = rValid;
  assign rChan.data  = rData;
  assign rChan.resp  = RespOkay;

endmodule

`default_nettype wire

// File: src/userCtrlRegs.sv
/*
  User registers: MDIO control and MDIO write data, written over AXI,
  sliced into the request levels for the MDIO engine
*/
`timescale 1ns/1ns
`default_nettype none

module userCtrlRegs (
  input  wire                   axiClk,
  input  wire                   arstN,
  input  axiLitePkg::regWrite_t regWrite,
  input  mdioPkg::regAddr_t     readAddr,
  output axiLitePkg::axiData_t  userRdata,
  output mdioPkg::mdioReq_t     mdioReq
);

  import axiLitePkg::*;
  import mdioPkg::*;

  axiData_t ctrlReg;
  axiData_t writeReg;

  //========================================
  // register writes
  //========================================
  // each register decodes its own word address
  always_ff @(posedge axiClk or negedge arstN) begin
    if (!arstN) begin
      ctrlReg  <= '0;
      writeReg <= '0;
    end else if (regWrite.strobe) begin
      if (regWrite.addr == UsrCtrlAddr) begin
        ctrlReg <= regWrite.data;
      end
      if (regWrite.addr == UsrWriteAddr) begin
        writeReg <= regWrite.data;
      end
    end
  end

  //========================================
  // read back
  //========================================
  // full 32 bits returned, zero outside our two addresses
  always_comb begin
    case (readAddr)
      UsrCtrlAddr:  userRdata = ctrlReg;
      UsrWriteAddr: userRdata = writeReg;
      default:      userRdata = '0;
    endcase
  end

  //========================================
  // MDIO request
  //========================================
  assign mdioReq.phyAddr = ctrlReg[CtrlPhyLsb +: PhyFieldWidth];
  assign mdioReq.regAddr = ctrlReg[CtrlRegLsb +: PhyFieldWidth];
  assign mdioReq.write   = ctrlReg[CtrlWriteBit];
  assign mdioReq.en      = ctrlReg[CtrlEnBit];
  // only the low half goes out on MDIO
  assign mdioReq.wrData  = writeReg[$bits(phyData_t)-1:0];

endmodule

`default_nettype wire

// File: src/phyShadowRegs.sv
/*
  PHY shadow registers: mdcClk-domain copies of the fourteen PHY registers,
  filled by the MDIO engine and read back over AXI
*/
`timescale 1ns/1ns
`default_nettype none

module phyShadowRegs (
  input  wire                  mdcClk,
  input  wire                  arstN,
  input  mdioPkg::mdioRecv_t   mdioRecv,
  input  mdioPkg::regAddr_t    readAddr,
  output axiLitePkg::axiData_t phyRdata
);

  import axiLitePkg::*;
  import mdioPkg::*;

  // slot order follows PhyMap
  phyData_t shadow [PhyRegCount];

  //========================================
  // updates from the MDIO engine
  //========================================
  // a strobe to an address outside the map matches no slot
  always_ff @(posedge mdcClk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < PhyRegCount; i++) begin
        shadow[i] <= '0;
      end
    end else if (mdioRecv.valid) begin
      for (int i = 0; i < PhyRegCount; i++) begin
        if (mdioRecv.regAddr == PhyMap[i]) begin
          shadow[i] <= mdioRecv.data;
        end
      end
    end
  end

  //========================================
  // AXI read side
  //========================================
  // readAddr comes from axiClk, shadows are quasi-static
  // so the word is taken without synchronizing
  // upper half always zero
  always_comb begin
    phyRdata = '0;
    for (int i = 0; i < PhyRegCount; i++) begin
      if (readAddr == PhyMap[i]) begin
        phyRdata[$bits(phyData_t)-1:0] = shadow[i];
      end
    end
  end

endmodule

`default_nettype wire

// File: src/mdioRegsTop.sv
/*
  MDIO register block top: AXI4-Lite slave, user control registers
  and the PHY shadow registers
*/
`timescale 1ns/1ns
`default_nettype none

module mdioRegsTop (
  input  wire                  axiClk,
  input  wire                  mdcClk,
  input  wire                  arstN,
  // AXI4-Lite slave port
  input  axiLitePkg::awChan_t  awChan,
  input  axiLitePkg::wChan_t   wChan,
  input  axiLitePkg::arChan_t  arChan,
  input  wire                  bready,
  input  wire                  rready,
  output logic                 awready,
  output logic                 wready,
  output logic                 arready,
  output axiLitePkg::bChan_t   bChan,
  output axiLitePkg::rChan_t   rChan,
  // MDIO engine
  output mdioPkg::mdioReq_t    mdioReq,
  input  mdioPkg::mdioRecv_t   mdioRecv,
  input  wire                  mdioBusy
);

  import axiLitePkg::*;
  import mdioPkg::*;

  regWrite_t regWrite;
  regAddr_t  readAddr;
  // each word is zero outside its own range, slave ORs them
  axiData_t  userRdata;
  axiData_t  phyRdata;

  axiLiteSlave i_axiLiteSlave (
    .axiClk    (axiClk),
    .arstN     (arstN),
    .awChan    (awChan),
    .wChan     (wChan),
    .arChan    (arChan),
    .bready    (bready),
    .rready    (rready),
    .awready   (awready),
    .wready    (wready),
    .arready   (arready),
    .bChan     (bChan),
    .rChan     (rChan),
    .mdioBusy  (mdioBusy),
    .regWrite  (regWrite),
    .readAddr  (readAddr),
    .userRdata (userRdata),
    .phyRdata  (phyRdata)
  );

  userCtrlRegs i_userCtrlRegs (
    .axiClk    (axiClk),
    .arstN     (arstN),
    .regWrite  (regWrite),
    .readAddr  (readAddr),
    .userRdata (userRdata),
    .mdioReq   (mdioReq)
  );

  // mdcClk domain
  phyShadowRegs i_phyShadowRegs (
    .mdcClk   (mdcClk),
    .arstN    (arstN),
    .mdioRecv (mdioRecv),
    .readAddr (readAddr),
    .phyRdata (phyRdata)
  );

endmodule

`default_nettype wire

// File: tests/tbTasks.svh
/*
  testbench helpers: AXI4-Lite master tasks, xorshift generator
  and compare tasks for the DUT's result types
*/
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// xorshift32, state kept in the testbench
function automatic axiData_t nextRand();
  rngState = rngState ^ (rngState << 13);
  rngState = rngState ^ (rngState >> 17);
  rngState = rngState ^ (rngState << 5);
  return rngState;
endfunction

//========================================
// compare tasks
//========================================
task automatic reportFailure(input string what);
  errorCount++;
  $display("[%s] %s", currentTest, what);
endtask

task automatic checkData(input string label, input axiData_t exp, input axiData_t act);
  checkCount++;
  if (act !== exp) begin
    errorCount++;
    $display("Error [%s] %s: expected %h, actual %h", currentTest, label, exp, act);
  end
endtask

task automatic checkReq(input string label, input mdioReq_t exp, input mdioReq_t act);
  checkCount++;
  if (act !== exp) begin
    errorCount++;
    $display("Error [%s] %s: expected %h, actual %h", currentTest, label, exp, act);
  end
endtask

task automatic checkResp(input string label, input axiResp_t exp, input axiResp_t act);
  checkCount++;
  if (act !== exp) begin
    errorCount++;
    $display("Error [%s] %s: expected %h, actual %h", currentTest, label, exp, act);
  end
endtask

//========================================
// AXI4-Lite master
//========================================
// latencies count edges from the edge that raised the valids
task automatic axiWrite(input axiAddr_t addr, input axiData_t data, input int holdCycles,
                        output axiResp_t resp, output int readyLat, output int validLat);
  int n;
  n = 0;
  @(posedge axiClk);
  awChan <= '{addr: addr, valid: 1'b1};
  wChan  <= '{data: data, valid: 1'b1};
  do begin
    @(posedge axiClk);
    n++;
  end while (!(awready && wready));
  readyLat = n;
  awChan.valid <= 1'b0;
  wChan.valid  <= 1'b0;
  do begin
    @(posedge axiClk);
    n++;
    if (awready || wready) reportFailure("awready/wready high for more than one cycle");
  end while (!bChan.valid);
  validLat = n;
  // back-pressure, bvalid has to wait for us
  repeat (holdCycles) begin
    @(posedge axiClk);
    if (!bChan.valid) reportFailure("bvalid dropped before bready");
  end
  bready <= 1'b1;
  @(posedge axiClk);
  if (!bChan.valid) reportFailure("bvalid missing at the write response handshake");
  resp = bChan.resp;
  bready <= 1'b0;
  @(posedge axiClk);
  if (bChan.valid) reportFailure("bvalid still high after the handshake");
endtask

task automatic axiRead(input axiAddr_t addr, input int holdCycles, output axiData_t data,
                       output axiResp_t resp, output int readyLat, output int validLat);
  int n;
  axiData_t first;
  n = 0;
  @(posedge axiClk);
  arChan <= '{addr: addr, valid: 1'b1};
  do begin
    @(posedge axiClk);
    n++;
  end while (!arready);
  readyLat = n;
  arChan.valid <= 1'b0;
  do begin
    @(posedge axiClk);
    n++;
    if (arready) reportFailure("arready high for more than one cycle");
  end while (!rChan.valid);
  validLat = n;
  first = rChan.data;
  // data must hold still until rready
  repeat (holdCycles) begin
    @(posedge axiClk);
    if (!rChan.valid) reportFailure("rvalid dropped before rready");
    if (rChan.data !== first) reportFailure("rdata changed while waiting for rready");
  end
  rready <= 1'b1;
  @(posedge axiClk);
  if (!rChan.valid) reportFailure("rvalid missing at the read handshake");
  if (rChan.data !== first) reportFailure("rdata changed at the read handshake");
  data = rChan.data;
  resp = rChan.resp;
  rready <= 1'b0;
  @(posedge axiClk);
  if (rChan.valid) reportFailure("rvalid still high after the handshake");
endtask

`endif

// File: tests/tbMdioRegs.sv
/*
  testbench for the MDIO register block with an AXI4-Lite master, an MDIO
  engine stand-in, a reference model of the register map and timing checks
*/
`timescale 1ns/1ns
`default_nettype none

module tbMdioRegs;

  import axiLitePkg::*;
  import mdioPkg::*;

  // ample margin over the summed test lengths
  localparam int TimeoutCycles = 4000;
  // LAN8720 register map
  localparam regAddr_t MappedAddrs [14] = '{
    6'h00, 6'h01, 6'h02, 6'h03, 6'h04, 6'h05, 6'h06,
    6'h11, 6'h12, 6'h1A, 6'h1B, 6'h1D, 6'h1E, 6'h1F
  };

  logic      axiClk;
  logic      mdcClk;
  logic      arstN;
  awChan_t   awChan;
  wChan_t    wChan;
  arChan_t   arChan;
  logic      bready;
  logic      rready;
  logic      awready;
  logic      wready;
  logic      arready;
  bChan_t    bChan;
  rChan_t    rChan;
  mdioReq_t  mdioReq;
  mdioRecv_t mdioRecv;
  logic      mdioBusy;

  // reference model of the register contents
  axiData_t ctrlModel;
  axiData_t writeModel;
  phyData_t shadowModel [64];

  axiData_t rngState;
  string    currentTest;
  int       errorCount;
  int       checkCount;
  int       testErrors;
  int       cycleCount;

  mdioRegsTop i_mdioRegsTop (
    .axiClk   (axiClk),
    .mdcClk   (mdcClk),
    .arstN    (arstN),
    .awChan   (awChan),
    .wChan    (wChan),
    .arChan   (arChan),
    .bready   (bready),
    .rready   (rready),
    .awready  (awready),
    .wready   (wready),
    .arready  (arready),
    .bChan    (bChan),
    .rChan    (rChan),
    .mdioReq  (mdioReq),
    .mdioRecv (mdioRecv),
    .mdioBusy (mdioBusy)
  );

  `include "tbTasks.svh"

  // 100 ns AXI clock and 400 ns MDC clock
  always #50 axiClk = ~axiClk;
  always #200 mdcClk = ~mdcClk;

  //========================================
  // reference model
  //========================================
  function automatic bit isMapped(input regAddr_t a);
    for (int i = 0; i < 14; i++) begin
      if (MappedAddrs[i] == a) return 1'b1;
    end
    return 1'b0;
  endfunction

  // word index sits on byte address bits 7:2
  function automatic axiAddr_t byteAddr(input regAddr_t a);
    return {{(AxiAddrWidth-RegAddrWidth-2){1'b0}}, a, 2'b00};
  endfunction

  // user registers in full, shadows zero-extended, everything else zero
  function automatic axiData_t expectRead(input regAddr_t a);
    if (a == UsrCtrlAddr) return ctrlModel;
    if (a == UsrWriteAddr) return writeModel;
    if (isMapped(a)) return {16'h0000, shadowModel[a]};
    return '0;
  endfunction

  // en bit 0, write bit 1, PHY 6:2, reg 11:7, low half of write data
  function automatic mdioReq_t expectReq();
    mdioReq_t r;
    r.phyAddr = ctrlModel[6:2];
    r.regAddr = ctrlModel[11:7];
    r.write   = ctrlModel[1];
    r.en      = ctrlModel[0];
    r.wrData  = writeModel[15:0];
    return r;
  endfunction

  //========================================
  // stimulus helpers
  //========================================
  // one-cycle receive strobe from the MDIO engine
  task automatic sendRecv(input regAddr_t a, input phyData_t d);
    @(posedge mdcClk);
    mdioRecv <= '{regAddr: a, valid: 1'b1, data: d};
    @(posedge mdcClk);
    mdioRecv.valid <= 1'b0;
    if (isMapped(a)) shadowModel[a] = d;
  endtask

  task automatic writeReg(input regAddr_t a, input axiData_t d, input int hold,
                          output int rLat, output int vLat);
    axiResp_t resp;
    axiWrite(byteAddr(a), d, hold, resp, rLat, vLat);
    checkResp($sformatf("write resp 0x%02h", a), RespOkay, resp);
    // shadow addresses drop AXI writes
    if (a == UsrCtrlAddr) ctrlModel = d;
    if (a == UsrWriteAddr) writeModel = d;
  endtask

  task automatic readReg(input regAddr_t a, input int hold, output int rLat, output int vLat);
    axiData_t data;
    axiResp_t resp;
    axiRead(byteAddr(a), hold, data, resp, rLat, vLat);
    checkData($sformatf("read 0x%02h", a), expectRead(a), data);
    checkResp($sformatf("read resp 0x%02h", a), RespOkay, resp);
  endtask

  task automatic beginTest(input string name);
    currentTest = name;
    testErrors  = errorCount;
  endtask

  task automatic finishTest();
    $display("test %-8s done, %0d errors", currentTest, errorCount - testErrors);
  endtask

  //========================================
  // tests
  //========================================
  task automatic resetTest();
    int rl;
    int vl;
    beginTest("reset");
    checkData("ready/valid flags", '0,
              {27'd0, awready, wready, arready, bChan.valid, rChan.valid});
    checkReq("mdioReq", '0, mdioReq);
    for (int i = 0; i < 14; i++) readReg(MappedAddrs[i], 0, rl, vl);
    readReg(UsrCtrlAddr, 0, rl, vl);
    readReg(UsrWriteAddr, 0, rl, vl);
    finishTest();
  endtask

  task automatic userRegTest();
    int rl;
    int vl;
    regAddr_t a;
    beginTest("userRegs");
    for (int i = 0; i < 8; i++) begin
      a = (i % 2 == 0) ? UsrCtrlAddr : UsrWriteAddr;
      writeReg(a, nextRand(), 0, rl, vl);
      readReg(a, 0, rl, vl);
      checkReq("mdioReq fields", expectReq(), mdioReq);
    end
    finishTest();
  endtask

  task automatic shadowTest();
    int rl;
    int vl;
    axiData_t r;
    beginTest("shadow");
    for (int i = 0; i < 14; i++) begin
      r = nextRand();
      sendRecv(MappedAddrs[i], r[15:0]);
    end
    for (int i = 0; i < 14; i++) readReg(MappedAddrs[i], 0, rl, vl);
    // strobes outside the map (0x20 too) must not land anywhere
    sendRecv(6'h07, 16'hdead);
    sendRecv(6'h20, 16'hbeef);
    sendRecv(6'h3f, 16'h1234);
    for (int i = 0; i < 14; i++) readReg(MappedAddrs[i], 0, rl, vl);
    readReg(UsrCtrlAddr, 0, rl, vl);
    readReg(6'h07, 0, rl, vl);
    readReg(6'h10, 0, rl, vl);
    readReg(6'h3f, 0, rl, vl);
    finishTest();
  endtask

  // ready on the second edge after the valids rise, response on the third
  task automatic timingTest();
    int rl;
    int vl;
    axiData_t r;
    axiData_t held;
    axiData_t data;
    axiResp_t resp;
    beginTest("timing");
    for (int i = 0; i < 4; i++) begin
      r = nextRand();
      writeReg(UsrWriteAddr, nextRand(), int'(r & 32'd3), rl, vl);
      checkData("awready/wready cycle", 32'd2, rl);
      checkData("bvalid cycle", 32'd3, vl);
      readReg(UsrWriteAddr, int'((r >> 4) & 32'd3), rl, vl);
      checkData("arready cycle", 32'd2, rl);
      checkData("rvalid cycle", 32'd3, vl);
    end
    // the MDIO engine rewrites the shadow while the read response waits
    held = expectRead(PhyCtrlAddr);
    fork
      axiRead(byteAddr(PhyCtrlAddr), 12, data, resp, rl, vl);
      begin
        repeat (4) @(posedge axiClk);
        sendRecv(PhyCtrlAddr, ~held[15:0]);
      end
    join
    checkData("rdata under back-pressure", held, data);
    checkResp("read resp under back-pressure", RespOkay, resp);
    readReg(PhyCtrlAddr, 0, rl, vl);
    finishTest();
  endtask

  task automatic busyTest();
    int rl;
    int vl;
    int rl2;
    int vl2;
    beginTest("busy");
    @(posedge mdcClk);
    mdioBusy <= 1'b1;
    // two sync flops plus a spare edge
    repeat (3) @(posedge axiClk);
    // the write wins, so the read returns the new control word
    fork
      writeReg(UsrCtrlAddr, nextRand(), 1, rl, vl);
      readReg(UsrCtrlAddr, 2, rl2, vl2);
      begin
        repeat (30) begin
          @(posedge axiClk);
          if (awready || wready || arready) reportFailure("ready given while mdioBusy was high");
        end
        @(posedge mdcClk);
        mdioBusy <= 1'b0;
      end
    join
    checkReq("mdioReq after busy", expectReq(), mdioReq);
    finishTest();
  endtask

  //========================================
  // sequence
  //========================================
  initial begin
    axiClk      = 1'b0;
    mdcClk      = 1'b0;
    arstN       = 1'b0;
    awChan      = '0;
    wChan       = '0;
    arChan      = '0;
    bready      = 1'b0;
    rready      = 1'b0;
    mdioRecv    = '0;
    mdioBusy    = 1'b0;
    ctrlModel   = '0;
    writeModel  = '0;
    rngState    = 32'd50;
    errorCount  = 0;
    checkCount  = 0;
    currentTest = "init";
    for (int i = 0; i < 64; i++) shadowModel[i] = '0;
    repeat (5) @(posedge axiClk);
    arstN <= 1'b1;
    @(posedge axiClk);
    resetTest();
    userRegTest();
    shadowTest();
    timingTest();
    busyTest();
    $display("checks %0d, errors %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  // cycle counter stops a hung run
  initial begin
    cycleCount = 0;
    while (cycleCount < TimeoutCycles) begin
      @(posedge axiClk);
      cycleCount++;
    end
    $display("timeout after %0d axiClk cycles, test %s never finished", cycleCount, currentTest);
    $display("** FAIL **");
    $finish;
  end

endmodule

`default_nettype wire

// File: mdioRegsTop.f
src/mdioPkg.sv
src/axiLitePkg.sv
src/axiLiteSlave.sv
src/userCtrlRegs.sv
src/phyShadowRegs.sv
src/mdioRegsTop.sv
tests/tbMdioRegs.sv
+incdir+tests

// File: Makefile
# Verilator flow for the MDIO register block

TOP = tbMdioRegs

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f mdioRegsTop.f --top-module mdioRegsTop

sim:
	verilator --binary --timing -f mdioRegsTop.f --top-module $(TOP) -o simv
	./obj_dir/simv | tee sim.log
	grep -qF '** PASS **' sim.log

clean:
	rm -rf obj_dir sim.log
